// File: verilog/fetch_cfg.svh
`ifndef FETCH_CFG_SVH
`define FETCH_CFG_SVH

// width of the request and packet tag, wraps modulo 2**bits
`define FETCH_TAG_BITS 8

// cache geometry
// words per line and number of lines, both powers of two
`define FETCH_LINE_WORDS 4
`define FETCH_LINES 16

// first fetch address after reset
`define FETCH_RESET_PC 32'h0000_0000

`endif

// File: verilog/fetch_pkg.sv
`include "fetch_cfg.svh"

package fetch_pkg;

	// request and packet tag
	typedef logic [`FETCH_TAG_BITS-1:0] fetch_tag_t;

	// packet handed to decode, 72 bits
	typedef struct packed {
		fetch_tag_t tag;
		logic [31:0] instruction;
		logic [31:0] pc;
	} fetch_packet_t;

	// target coming back from execute, 40 bits
	typedef struct packed {
		fetch_tag_t tag;
		logic [31:0] pc_next;
	} branch_resolve_t;

	// fetch unit to cache
	typedef struct packed {
		fetch_tag_t tag;
		logic [31:0] address;
	} cache_req_t;

	// cache to fetch unit
	typedef struct packed {
		fetch_tag_t tag;
		logic [31:0] rdata;
	} cache_rsp_t;

	// major opcodes the front end cares about
	// OP_OTHER stands for every other class, coded as OP-IMM
	typedef enum logic [6:0] {
		OP_BRANCH = 7'b1100011,
		OP_JAL = 7'b1101111,
		OP_JALR = 7'b1100111,
		OP_OTHER = 7'b0010011
	} opcode_e;

	typedef enum logic [1:0] {
		FETCH_ISSUE = 2'd0,
		FETCH_WAIT = 2'd1,
		FETCH_HOLD = 2'd2
	} fetch_state_e;

	typedef enum logic {
		CACHE_LOOKUP = 1'b0,
		CACHE_FILL = 1'b1
	} cache_state_e;

	// map the low seven bits of a word onto the opcode classes
	function automatic opcode_e decode_opcode(input logic [31:0] word);
		case (word[6:0])
			OP_BRANCH: return OP_BRANCH;
			OP_JAL: return OP_JAL;
			OP_JALR: return OP_JALR;
			default: return OP_OTHER;
		endcase
	endfunction

endpackage

// File: verilog/instr_cache.sv
`timescale 1ns/1ns

`include "fetch_cfg.svh"

module instr_cache (
	input logic i_clock,
	input logic i_reset,

	// tagged request and response
	input fetch_pkg::cache_req_t i_req,
	output fetch_pkg::cache_rsp_t o_rsp,

	// line fill bus
	output logic o_bus_request,
	input logic i_bus_ready,
	output logic [31:0] o_bus_address,
	input logic [31:0] i_bus_rdata
);

	import fetch_pkg::*;

	localparam int WORD_BITS = $clog2(`FETCH_LINE_WORDS);
	localparam int INDEX_BITS = $clog2(`FETCH_LINES);
	localparam int ATAG_BITS = 32 - 2 - WORD_BITS - INDEX_BITS;
	localparam int DEPTH = `FETCH_LINES * `FETCH_LINE_WORDS;

	// byte address as seen by the cache
	typedef struct packed {
		logic [ATAG_BITS-1:0] atag;
		logic [INDEX_BITS-1:0] index;
		logic [WORD_BITS-1:0] word;
		logic [1:0] byte_offset;
	} line_addr_t;

	// storage, one flat word array for all lines
	logic [31:0] data_mem [DEPTH];
	logic [ATAG_BITS-1:0] atag_mem [`FETCH_LINES];
	logic [`FETCH_LINES-1:0] line_valid;

	cache_state_e state;

	// last request tag taken in, a different value means a new request
	fetch_tag_t seen_tag;

	// the request that missed, held for the whole fill
	cache_req_t pending;
	logic [WORD_BITS-1:0] fill_count;
	logic [31:0] fill_word;

	line_addr_t req_addr;
	line_addr_t pend_addr;
	line_addr_t bus_addr;

	logic new_request;
	logic hit;
	logic beat;
	logic last_beat;
	logic beat_is_wanted;

	assign req_addr = line_addr_t'(i_req.address);
	assign pend_addr = line_addr_t'(pending.address);

	assign new_request = (state == CACHE_LOOKUP) && (i_req.tag != seen_tag);
	assign hit = line_valid[req_addr.index] && (atag_mem[req_addr.index] == req_addr.atag);

	// fill always walks the line from its base
	always_comb begin
		bus_addr.atag = pend_addr.atag;
		bus_addr.index = pend_addr.index;
		bus_addr.word = fill_count;
		bus_addr.byte_offset = 2'b00;
	end

	assign o_bus_request = (state == CACHE_FILL);
	assign o_bus_address = bus_addr;

	// one word moves on every edge with request and ready high
	assign beat = o_bus_request && i_bus_ready;
	assign last_beat = beat && (fill_count == WORD_BITS'(`FETCH_LINE_WORDS - 1));
	assign beat_is_wanted = (fill_count == pend_addr.word);

	// line storage
	always_ff @(posedge i_clock) begin
		if (beat) begin
			data_mem[{pend_addr.index, fill_count}] <= i_bus_rdata;
		end
		if (last_beat) begin
			atag_mem[pend_addr.index] <= pend_addr.atag;
		end
	end

	// keep the requested word as it goes by
	always_ff @(posedge i_clock) begin
		if (beat && beat_is_wanted) begin
			fill_word <= i_bus_rdata;
		end
	end

	always_ff @(posedge i_clock) begin
		if (new_request && !hit) begin
			pending <= i_req;
		end
	end

	// lookup and fill control
	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state <= CACHE_LOOKUP;
			seen_tag <= '0;
			line_valid <= '0;
			fill_count <= '0;
			o_rsp <= '0;
		end
		else begin
			case (state)
				CACHE_LOOKUP: begin
					if (new_request) begin
						seen_tag <= i_req.tag;
						if (hit) begin
							o_rsp.tag <= i_req.tag;
							o_rsp.rdata <= data_mem[{req_addr.index, req_addr.word}];
						end
						else begin
							fill_count <= '0;
							state <= CACHE_FILL;
						end
					end
				end

				CACHE_FILL: begin
					if (beat) begin
						fill_count <= fill_count + 1'b1;
					end
					if (last_beat) begin
						line_valid[pend_addr.index] <= 1'b1;
						// answer the request that missed
						o_rsp.tag <= pending.tag;
						o_rsp.rdata <= beat_is_wanted ? i_bus_rdata : fill_word;
						state <= CACHE_LOOKUP;
					end
				end

				default: begin
					state <= CACHE_LOOKUP;
				end
			endcase
		end
	end

endmodule

// File: verilog/fetch_unit.sv
`timescale 1ns/1ns

`include "fetch_cfg.svh"

module fetch_unit (
	input logic i_clock,
	input logic i_reset,
	input logic i_stall,

	// resolution from execute and packet to decode
	input fetch_pkg::branch_resolve_t i_resolve,
	output fetch_pkg::fetch_packet_t o_packet,

	// bus, handled by the cache
	output logic o_bus_request,
	input logic i_bus_ready,
	output logic [31:0] o_bus_address,
	input logic [31:0] i_bus_rdata
);

	import fetch_pkg::*;

	fetch_state_e state;

	// address of the word currently asked for
	logic [31:0] pc;
	logic [31:0] pc_plus4;

	// tag of the outstanding cache request
	fetch_tag_t req_tag;
	fetch_tag_t next_tag;

	cache_req_t cache_req;
	cache_rsp_t cache_rsp;
	fetch_packet_t packet_next;

	opcode_e opcode;
	logic is_transfer;
	logic rsp_match;
	logic resolve_match;
	logic issue_next;

	instr_cache u_cache (
		.i_clock(i_clock),
		.i_reset(i_reset),

		.i_req(cache_req),
		.o_rsp(cache_rsp),

		.o_bus_request(o_bus_request),
		.i_bus_ready(i_bus_ready),
		.o_bus_address(o_bus_address),
		.i_bus_rdata(i_bus_rdata)
	);

	assign pc_plus4 = pc + 32'd4;
	assign next_tag = req_tag + fetch_tag_t'(1);

	assign rsp_match = (state == FETCH_WAIT) && (cache_rsp.tag == req_tag);
	assign resolve_match = (state == FETCH_HOLD) && (i_resolve.tag == o_packet.tag);

	// branches and jumps stop the stream until execute answers
	assign opcode = decode_opcode(cache_rsp.rdata);
	assign is_transfer = (opcode != OP_OTHER);

	// sequential words go out back to back
	assign issue_next = rsp_match && !is_transfer && !i_stall;

	// the cache sees the next request on the same edge the packet is taken,
	// which keeps a run of hits at one packet per cycle
	always_comb begin
		cache_req.tag = req_tag;
		cache_req.address = pc;
		if (issue_next) begin
			cache_req.tag = next_tag;
			cache_req.address = pc_plus4;
		end
	end

	always_comb begin
		packet_next.tag = req_tag;
		packet_next.instruction = cache_rsp.rdata;
		packet_next.pc = pc;
	end

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state <= FETCH_ISSUE;
			pc <= `FETCH_RESET_PC;
			req_tag <= '0;
			o_packet <= '0;
		end
		else if (!i_stall) begin
			case (state)
				FETCH_ISSUE: begin
					req_tag <= next_tag;
					state <= FETCH_WAIT;
				end

				FETCH_WAIT: begin
					if (rsp_match) begin
						o_packet <= packet_next;
						pc <= pc_plus4;
						if (is_transfer) begin
							state <= FETCH_HOLD;
						end
						else begin
							req_tag <= next_tag;
						end
					end
				end

				FETCH_HOLD: begin
					// only the resolution for our own packet counts
					if (resolve_match) begin
						pc <= i_resolve.pc_next;
						state <= FETCH_ISSUE;
					end
				end

				default: begin
					state <= FETCH_ISSUE;
				end
			endcase
		end
	end

endmodule

// File: verilog/fetch_top.sv
`timescale 1ns/1ns

module fetch_top (
	input logic i_clock,
	input logic i_reset,
	input logic i_stall,

	// execute side
	input fetch_pkg::branch_resolve_t i_resolve,
	output fetch_pkg::fetch_packet_t o_packet,

	// memory bus
	output logic o_bus_request,
	input logic i_bus_ready,
	output logic [31:0] o_bus_address,
	input logic [31:0] i_bus_rdata
);

	// cache sits inside the fetch unit
	fetch_unit u_fetch (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_stall(i_stall),

		.i_resolve(i_resolve),
		.o_packet(o_packet),

		.o_bus_request(o_bus_request),
		.i_bus_ready(i_bus_ready),
		.o_bus_address(o_bus_address),
		.i_bus_rdata(i_bus_rdata)
	);

endmodule

// File: test/fetch_properties.sv
`timescale 1ns/1ns

module fetch_properties (
	input logic i_clock,
	input logic i_reset,
	input logic i_stall,
	input fetch_pkg::fetch_packet_t o_packet,
	input logic o_bus_request,
	input logic i_bus_ready,
	input logic [31:0] o_bus_address
);

	// request and address hold until the slave is ready
	bus_hold: assert property (
		@(posedge i_clock) disable iff (i_reset)
		(o_bus_request && !i_bus_ready) |=> (o_bus_request && $stable(o_bus_address))
	) else $error("bus request or address changed before ready");

	// a stalled fetch unit keeps its packet
	stall_hold: assert property (
		@(posedge i_clock) disable iff (i_reset)
		i_stall |=> $stable(o_packet)
	) else $error("o_packet changed during a stall");

	// no bus traffic straight out of reset
	reset_quiet: assert property (
		@(posedge i_clock) i_reset |=> !o_bus_request
	) else $error("o_bus_request high in the cycle after reset");

endmodule

// File: test/fetch_tb.sv
`timescale 1ns/1ns

`include "fetch_cfg.svh"

module fetch_tb;

	import fetch_pkg::*;

	localparam int NUM_TESTS = 5;
	localparam int LINE_BYTES = `FETCH_LINE_WORDS * 4;
	localparam int PACKET_LIMIT = 200;
	localparam fetch_tag_t PARK_FLIP = fetch_tag_t'(1 << (`FETCH_TAG_BITS - 1));

	logic i_clock = 1'b0;
	logic i_reset;
	logic i_stall;
	branch_resolve_t i_resolve;
	fetch_packet_t o_packet;
	logic o_bus_request;
	logic i_bus_ready = 1'b0;
	logic [31:0] o_bus_address;
	logic [31:0] i_bus_rdata = '0;

	// program memory where unset words read as a fill pattern
	logic [31:0] mem [logic [31:0]];

	fetch_packet_t packets [$];
	logic [31:0] bus_log [$];
	fetch_tag_t last_tag = '0;
	fetch_packet_t last_packet;

	// model of the stream the DUT should produce
	logic [31:0] exp_pc;
	fetch_tag_t exp_tag;

	logic [15:0] lfsr = 16'd59;
	int bus_wait = -1;

	fetch_top DUT (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_stall(i_stall),
		.i_resolve(i_resolve),
		.o_packet(o_packet),
		.o_bus_request(o_bus_request),
		.i_bus_ready(i_bus_ready),
		.o_bus_address(o_bus_address),
		.i_bus_rdata(i_bus_rdata)
	);

	bind fetch_top fetch_properties props (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_stall(i_stall),
		.o_packet(o_packet),
		.o_bus_request(o_bus_request),
		.i_bus_ready(i_bus_ready),
		.o_bus_address(o_bus_address)
	);

	always #2 i_clock = ~i_clock;

	// 16-bit Fibonacci LFSR with taps 16 14 13 11
	function automatic logic [15:0] lfsr_step(input logic [15:0] state);
		return {state[14:0], state[15] ^ state[13] ^ state[12] ^ state[10]};
	endfunction

	function automatic int random_bits(input int count);
		int value;
		value = 0;
		for (int i = 0; i < count; i++) begin
			lfsr = lfsr_step(lfsr);
			value = (value << 1) | int'(lfsr[0]);
		end
		return value;
	endfunction

	// every address bit shows up in the fill word and the opcode stays OP-IMM
	function automatic logic [31:0] mem_word(input logic [31:0] address);
		if (mem.exists(address)) begin
			return mem[address];
		end
		return {address[31:7] ^ {18'h0, address[6:0]} ^ 25'h15a_3c69, OP_OTHER};
	endfunction

	function automatic logic [31:0] make_word(input opcode_e op, input logic [24:0] fields);
		return {fields, op};
	endfunction

	function automatic logic [31:0] line_base(input logic [31:0] address);
		return address & ~(32'(LINE_BYTES) - 32'd1);
	endfunction

	task automatic fail_run();
		$display("CHECKS FAILED");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic check_packet(input fetch_packet_t actual, input fetch_packet_t expected,
		input string name);
		if (actual !== expected) begin
			$display("Mismatch at %0t ns: %s got %h/%h/%h, expected %h/%h/%h (tag/word/pc)",
				$time, name, actual.tag, actual.instruction, actual.pc,
				expected.tag, expected.instruction, expected.pc);
			fail_run();
		end
	endtask

	task automatic check_tag(input fetch_tag_t actual, input fetch_tag_t expected,
		input string name);
		if (actual !== expected) begin
			$display("Mismatch at %0t ns: %s got %h, expected %h", $time, name, actual, expected);
			fail_run();
		end
	endtask

	task automatic check_word(input logic [31:0] actual, input logic [31:0] expected,
		input string name);
		if (actual !== expected) begin
			$display("Mismatch at %0t ns: %s got %h, expected %h", $time, name, actual, expected);
			fail_run();
		end
	endtask

	// memory bus slave with 0 to 3 idle cycles before each word
	always @(negedge i_clock) begin
		if (i_bus_ready) begin
			bus_wait = -1;
		end
		i_bus_ready = 1'b0;
		if (o_bus_request && !i_reset) begin
			if (bus_wait < 0) begin
				bus_wait = random_bits(2);
			end
			if (bus_wait == 0) begin
				i_bus_rdata = mem_word(o_bus_address);
				i_bus_ready = 1'b1;
				bus_log.push_back(o_bus_address);
			end
			else begin
				bus_wait--;
			end
		end
		else begin
			bus_wait = -1;
		end
	end

	// a new tag marks a new packet and is one above the last, wrapping
	always @(negedge i_clock) begin
		if (i_reset) begin
			last_tag = '0;
		end
		else if (o_packet.tag != last_tag) begin
			check_tag(o_packet.tag, last_tag + fetch_tag_t'(1), "o_packet.tag");
			packets.push_back(o_packet);
			last_tag = o_packet.tag;
		end
	end

	initial begin
		repeat (NUM_TESTS * 2000) @(posedge i_clock);
		$display("watchdog expired after %0d cycles, the tests did not finish",
			NUM_TESTS * 2000);
		$display("CHECKS FAILED");
		$fatal(1, "timeout");
	end

	task automatic apply_reset();
		fetch_packet_t zero;
		zero = '0;
		@(negedge i_clock);
		i_reset = 1'b1;
		i_stall = 1'b0;
		i_resolve.tag = PARK_FLIP;
		i_resolve.pc_next = '0;
		repeat (16) @(negedge i_clock);
		check_packet(o_packet, zero, "o_packet in reset");
		packets.delete();
		bus_log.delete();
		exp_pc = `FETCH_RESET_PC;
		exp_tag = '0;
		i_reset = 1'b0;
	endtask

	task automatic next_packet(output fetch_packet_t packet);
		int waited;
		waited = 0;
		@(posedge i_clock);
		while (packets.size() == 0) begin
			@(posedge i_clock);
			waited++;
			if (waited > PACKET_LIMIT) begin
				$display("no packet came out within %0d cycles at %0t ns", PACKET_LIMIT, $time);
				fail_run();
			end
		end
		packet = packets.pop_front();
	endtask

	// next packet follows from model pc, memory and tag + 1
	task automatic expect_packet();
		fetch_packet_t actual;
		fetch_packet_t expected;
		expected.tag = exp_tag + fetch_tag_t'(1);
		expected.instruction = mem_word(exp_pc);
		expected.pc = exp_pc;
		next_packet(actual);
		check_packet(actual, expected, "o_packet");
		last_packet = actual;
		exp_tag = expected.tag;
		exp_pc = exp_pc + 32'd4;
	endtask

	task automatic expect_no_packet(input int cycles);
		repeat (cycles) @(posedge i_clock);
		if (packets.size() != 0) begin
			$display("a packet came out at %0t ns while the fetch unit should hold", $time);
			fail_run();
		end
	endtask

	// one cycle of resolution and then a tag no held packet carries
	task automatic send_resolve(input fetch_tag_t tag, input logic [31:0] pc_next);
		@(negedge i_clock);
		i_resolve.tag = tag;
		i_resolve.pc_next = pc_next;
		@(negedge i_clock);
		i_resolve.tag = tag ^ PARK_FLIP;
	endtask

	task automatic resolve_to(input logic [31:0] pc_next);
		send_resolve(exp_tag, pc_next);
		exp_pc = pc_next;
	endtask

	// one fill is the whole line from its base up
	task automatic check_fill(input logic [31:0] base);
		for (int i = 0; i < `FETCH_LINE_WORDS; i++) begin
			if (bus_log.size() == 0) begin
				$display("the fill of line %h ended after %0d words", base, i);
				fail_run();
			end
			check_word(bus_log.pop_front(), base + 32'(4 * i), "o_bus_address");
		end
	endtask

	task automatic sequential_stream();
		mem.delete();
		apply_reset();
		for (int n = 0; n < 300; n++) begin
			expect_packet();
			if (line_base(last_packet.pc) == last_packet.pc) begin
				check_fill(last_packet.pc);
			end
		end
	endtask

	task automatic branch_hold();
		mem.delete();
		mem[32'h8] = make_word(OP_BRANCH, 25'h00a_5b1);
		mem[32'h108] = make_word(OP_JAL, 25'h123_4567);
		mem[32'h204] = make_word(OP_JALR, 25'h0f0_0f0);
		apply_reset();
		repeat (3) expect_packet();
		expect_no_packet(20);
		resolve_to(32'h100);
		repeat (3) expect_packet();
		expect_no_packet(20);
		resolve_to(32'h200);
		repeat (2) expect_packet();
		expect_no_packet(20);
		resolve_to(32'h40);
		repeat (4) expect_packet();
	endtask

	task automatic wrong_tag_ignored();
		mem.delete();
		mem[32'h4] = make_word(OP_JAL, 25'h05a_5a5);
		apply_reset();
		repeat (2) expect_packet();
		send_resolve(exp_tag + fetch_tag_t'(1), 32'h300);
		expect_no_packet(10);
		send_resolve(exp_tag - fetch_tag_t'(1), 32'h300);
		expect_no_packet(10);
		resolve_to(32'h80);
		repeat (3) expect_packet();
	endtask

	task automatic stall_release();
		fetch_packet_t held;
		int count;
		int length;
		mem.delete();
		apply_reset();
		for (int round = 0; round < 6; round++) begin
			expect_packet();
			count = random_bits(3);
			length = random_bits(4) + 2;
			repeat (count) expect_packet();
			@(negedge i_clock);
			i_stall = 1'b1;
			held = o_packet;
			repeat (length) begin
				@(negedge i_clock);
				check_packet(o_packet, held, "o_packet during stall");
			end
			i_stall = 1'b0;
		end
		repeat (8) expect_packet();
	endtask

	task automatic cache_fill_reuse();
		mem.delete();
		mem[32'h18] = make_word(OP_JAL, 25'h1c3_0a0);
		apply_reset();
		expect_packet();
		check_fill(32'h0);
		repeat (4) expect_packet();
		check_fill(32'h10);
		repeat (2) expect_packet();
		// back into lines 0 and 1 with hits only
		resolve_to(32'h4);
		repeat (6) expect_packet();
		if (bus_log.size() != 0) begin
			$display("the bus was used while replaying cached lines at %0t ns", $time);
			fail_run();
		end
		// miss in the middle of a line
		resolve_to(32'h348);
		expect_packet();
		check_fill(32'h340);
		repeat (2) expect_packet();
		check_fill(32'h350);
	endtask

	initial begin
		i_reset = 1'b1;
		i_stall = 1'b0;
		i_resolve = '0;
		sequential_stream();
		branch_hold();
		wrong_tag_ignored();
		stall_release();
		cache_fill_reuse();
		$display("ALL CHECKS PASSED");
		$finish;
	end

endmodule

// File: filelist.f
+incdir+verilog
verilog/fetch_pkg.sv
verilog/instr_cache.sv
verilog/fetch_unit.sv
verilog/fetch_top.sv
test/fetch_properties.sv
test/fetch_tb.sv

// File: run_sim.sh
#!/bin/sh
# build the fetch front end with its testbench, run it and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module fetch_tb \
	-f filelist.f -o fetch_sim \
	&& ./obj_dir/fetch_sim 2>&1 | tee /dev/stderr | grep -q "ALL CHECKS PASSED" \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }
